// ==== files.f ====
editor_pkg.sv
ps2_receiver.sv
key_decoder.sv
cursor_blink.sv
text_cursor.sv
text_editor.sv
tb_text_editor.sv

// ==== Makefile ====
TOP = tb_text_editor

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --top-module $(TOP) -f files.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "test passed" > /dev/null

clean:
	rm -rf obj_dir

// ==== tb_text_editor.sv ====
module tb_text_editor;

    localparam int COLS      = 40;
    localparam int ROWS      = 15;
    localparam int BLINK_DIV = 64;
    localparam int TIMEOUT   = 2000;
    localparam int NUM_KEYS  = 300;

    // Set 2 make codes, entry 0 in the low byte
    localparam logic [207:0] LETTER_SC = {8'h1A, 8'h35, 8'h22, 8'h1D, 8'h2A, 8'h3C, 8'h2C,
                                          8'h1B, 8'h2D, 8'h15, 8'h4D, 8'h44, 8'h31, 8'h3A,
                                          8'h4B, 8'h42, 8'h3B, 8'h43, 8'h33, 8'h34, 8'h2B,
                                          8'h24, 8'h23, 8'h21, 8'h32, 8'h1C};
    localparam logic [79:0]  DIGIT_SC  = {8'h46, 8'h3E, 8'h3D, 8'h36, 8'h2E, 8'h25, 8'h26,
                                          8'h1E, 8'h16, 8'h45};
    localparam logic [47:0]  MOVE_SC   = {8'h69, 8'h6C, 8'h74, 8'h6B, 8'h72, 8'h75};  // By move_e

    logic                    clk;
    logic                    reset;
    logic                    ps2_clk;
    logic                    ps2_dat;
    logic                    write_valid;
    editor_pkg::cell_write_t cell_write;
    editor_pkg::cursor_out_t cursor;

    editor_pkg::cell_write_t write_q[$];
    logic                    vis_q[$];
    logic                    vis_pending = 1'b0;
    logic [31:0]             rng_state;
    int                      exp_col;
    int                      exp_row;
    logic                    shift_held;

    text_editor #(.COLS(COLS), .ROWS(ROWS), .BLINK_DIV(BLINK_DIV)) i_text_editor
    (
        .clk         (clk),
        .reset       (reset),
        .ps2_clk     (ps2_clk),
        .ps2_dat     (ps2_dat),
        .write_valid (write_valid),
        .cell_write  (cell_write),
        .cursor      (cursor)
    );

    always #50 clk = ~clk;

    // Capture writes mid-cycle, visible level one cycle later
    always @(negedge clk)
    begin
        if (vis_pending)
            vis_q.push_back(cursor.visible);
        vis_pending = !reset && write_valid;
        if (!reset && write_valid)
            write_q.push_back(cell_write);
    end

    task automatic abort_run();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_write(input editor_pkg::cell_write_t got,
                               input editor_pkg::cell_write_t exp);
        if (got !== exp)
        begin
            $display("MISMATCH cell_write got %h expected %h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_pos(input editor_pkg::cursor_pos_t got,
                             input editor_pkg::cursor_pos_t exp);
        if (got !== exp)
        begin
            $display("MISMATCH cursor.pos got %h expected %h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_visible(input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("MISMATCH cursor.visible got %h expected %h", got, exp);
            abort_run();
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #10;
        end
    endtask

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int pick(input int n);
        logic [31:0] r;
        r = next_random();
        return int'(r[31:16]) % n;  // Upper bits are the better ones
    endfunction

    // 8 system cycles per keyboard half-period
    task automatic ps2_send(input editor_pkg::scan_t code, input logic bad_parity,
                            input logic bad_stop);
        logic [10:0] frame;
        frame = {~bad_stop, (~^code) ^ bad_parity, code, 1'b0};
        for (int i = 0; i < 11; i++)
        begin
            ps2_dat = frame[i];
            wait_cycles(8);
            ps2_clk = 1'b0;
            wait_cycles(8);
            ps2_clk = 1'b1;
        end
        ps2_dat = 1'b1;
        wait_cycles(8);
    endtask

    function automatic editor_pkg::cursor_pos_t model_pos();
        editor_pkg::cursor_pos_t p;
        p.col = editor_pkg::col_t'(exp_col);
        p.row = editor_pkg::row_t'(exp_row);
        return p;
    endfunction

    task automatic model_advance();
        if (exp_col == COLS - 1)
        begin
            exp_col = 0;
            exp_row = (exp_row == ROWS - 1) ? 0 : exp_row + 1;
        end
        else
            exp_col++;
    endtask

    task automatic model_move(input editor_pkg::move_e m);
        case (m)
            editor_pkg::MOVE_UP:    exp_row = (exp_row == 0) ? ROWS - 1 : exp_row - 1;
            editor_pkg::MOVE_DOWN:  exp_row = (exp_row == ROWS - 1) ? 0 : exp_row + 1;
            editor_pkg::MOVE_LEFT:
            begin
                if (exp_col == 0)
                begin
                    exp_col = COLS - 1;
                    exp_row = (exp_row == 0) ? ROWS - 1 : exp_row - 1;
                end
                else
                    exp_col--;
            end
            editor_pkg::MOVE_RIGHT: model_advance();
            editor_pkg::MOVE_HOME:  exp_col = 0;
            editor_pkg::MOVE_END:   exp_col = COLS - 1;
            default:                exp_col = exp_col;
        endcase
    endtask

    task automatic expect_no_write(input string what);
        if (write_q.size() != 0)
        begin
            $display("Unexpected write_valid after %s", what);
            abort_run();
        end
        check_pos(cursor.pos, model_pos());
    endtask

    task automatic wait_for_write();
        int n;
        n = 0;
        while (vis_q.size() == 0 && n < TIMEOUT)
        begin
            wait_cycles(1);
            n++;
        end
        if (vis_q.size() == 0)
        begin
            $display("Timeout: no write_valid after a printable key");
            abort_run();
        end
    endtask

    task automatic type_char(input editor_pkg::scan_t code, input editor_pkg::ascii_t ch);
        editor_pkg::cell_write_t exp;
        exp.pos = model_pos();
        exp.ch  = ch;
        ps2_send(code, 1'b0, 1'b0);
        wait_for_write();
        check_write(write_q.pop_front(), exp);
        check_visible(vis_q.pop_front(), 1'b1);
        model_advance();
        ps2_send(editor_pkg::SC_BREAK, 1'b0, 1'b0);
        ps2_send(code, 1'b0, 1'b0);
        expect_no_write("a key release");
    endtask

    task automatic type_letter(input int idx);
        type_char(LETTER_SC[idx*8 +: 8], editor_pkg::ascii_t'((shift_held ? 65 : 97) + idx));
    endtask

    task automatic type_digit(input int idx);
        type_char(DIGIT_SC[idx*8 +: 8], editor_pkg::ascii_t'(48 + idx));
    endtask

    task automatic move_key(input editor_pkg::move_e m);
        editor_pkg::scan_t code;
        code = MOVE_SC[int'(m)*8 +: 8];
        ps2_send(editor_pkg::SC_EXTEND, 1'b0, 1'b0);
        ps2_send(code, 1'b0, 1'b0);
        ps2_send(editor_pkg::SC_EXTEND, 1'b0, 1'b0);
        ps2_send(editor_pkg::SC_BREAK, 1'b0, 1'b0);
        ps2_send(code, 1'b0, 1'b0);
        model_move(m);
        expect_no_write("a move key");
    endtask

    task automatic shift_key(input logic press, input editor_pkg::scan_t code);
        if (!press)
            ps2_send(editor_pkg::SC_BREAK, 1'b0, 1'b0);
        ps2_send(code, 1'b0, 1'b0);
        shift_held = press;
        expect_no_write("a shift key");
    endtask

    task automatic bad_frame(input logic bad_parity);
        ps2_send(LETTER_SC[pick(26)*8 +: 8], bad_parity, !bad_parity);
        expect_no_write("a corrupted frame");
    endtask

    task automatic random_key();
        int sel;
        sel = pick(100);
        if (sel < 44)
            type_letter(pick(26));
        else if (sel < 54)
            type_digit(pick(10));
        else if (sel < 58)
            type_char(8'h29, 7'h20);  // Space
        else if (sel < 80)
            move_key(editor_pkg::move_e'(pick(6)));
        else if (sel < 92)
            shift_key(sel < 86, (pick(2) == 0) ? editor_pkg::SC_LSHIFT : editor_pkg::SC_RSHIFT);
        else
            bad_frame(pick(2) == 0);
    endtask

    // Idle blink, one toggle every BLINK_DIV cycles
    task automatic check_blink();
        int   n;
        logic level;
        level = cursor.visible;
        n     = 0;
        while (cursor.visible === level && n < TIMEOUT)
        begin
            wait_cycles(1);
            n++;
        end
        if (cursor.visible === level)
        begin
            $display("Timeout: cursor.visible never toggled while idle");
            abort_run();
        end
        for (int p = 0; p < 4; p++)
        begin
            level = cursor.visible;
            for (int i = 1; i < BLINK_DIV; i++)
            begin
                wait_cycles(1);
                check_visible(cursor.visible, level);
            end
            wait_cycles(1);
            check_visible(cursor.visible, ~level);
        end
    endtask

    initial
    begin
        clk        = 1'b0;
        reset      = 1'b1;
        ps2_clk    = 1'b1;
        ps2_dat    = 1'b1;
        rng_state  = 32'h4a14e29b;
        exp_col    = 0;
        exp_row    = 0;
        shift_held = 1'b0;
        repeat (8) @(posedge clk);
        #10;
        reset = 1'b0;
        check_pos(cursor.pos, model_pos());
        check_visible(cursor.visible, 1'b1);

        shift_key(1'b1, editor_pkg::SC_LSHIFT);
        type_letter(0);
        shift_key(1'b0, editor_pkg::SC_LSHIFT);
        type_letter(0);
        move_key(editor_pkg::MOVE_UP);    // Row 0 wraps to the bottom row
        move_key(editor_pkg::MOVE_END);
        type_digit(7);                    // Bottom right corner back to 0,0
        move_key(editor_pkg::MOVE_LEFT);
        move_key(editor_pkg::MOVE_HOME);
        bad_frame(1'b1);
        bad_frame(1'b0);

        for (int k = 0; k < NUM_KEYS; k++)
            random_key();

        check_blink();
        $display("test passed");
        $finish;
    end

endmodule

// ==== text_editor.sv ====
module text_editor
#(
    parameter int COLS      = 40,
    parameter int ROWS      = 15,
    parameter int BLINK_DIV = 25_000_000
)
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    ps2_clk,
    input  logic                    ps2_dat,
    output logic                    write_valid,
    output editor_pkg::cell_write_t cell_write,
    output editor_pkg::cursor_out_t cursor
);

    logic                   byte_valid;
    editor_pkg::scan_t      rx_byte;
    logic                   key_valid;
    editor_pkg::key_event_t key;
    logic                   cursor_on;

    ps2_receiver i_ps2_receiver
    (
        .clk        (clk),
        .reset      (reset),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat),
        .byte_valid (byte_valid),
        .rx_byte    (rx_byte)
    );

    key_decoder i_key_decoder
    (
        .clk        (clk),
        .reset      (reset),
        .byte_valid (byte_valid),
        .rx_byte    (rx_byte),
        .key_valid  (key_valid),
        .key        (key)
    );

    cursor_blink #(.BLINK_DIV(BLINK_DIV)) i_cursor_blink
    (
        .clk       (clk),
        .reset     (reset),
        .key_valid (key_valid),
        .cursor_on (cursor_on)
    );

    text_cursor #(.COLS(COLS), .ROWS(ROWS)) i_text_cursor
    (
        .clk         (clk),
        .reset       (reset),
        .key_valid   (key_valid),
        .key         (key),
        .cursor_on   (cursor_on),
        .write_valid (write_valid),
        .cell_write  (cell_write),
        .cursor      (cursor)
    );

endmodule

// ==== text_cursor.sv ====
module text_cursor
#(
    parameter int COLS = 40,
    parameter int ROWS = 15
)
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    key_valid,
    input  editor_pkg::key_event_t  key,
    input  logic                    cursor_on,
    output logic                    write_valid,
    output editor_pkg::cell_write_t cell_write,
    output editor_pkg::cursor_out_t cursor
);

    localparam editor_pkg::col_t LAST_COL = editor_pkg::col_t'(COLS - 1);
    localparam editor_pkg::row_t LAST_ROW = editor_pkg::row_t'(ROWS - 1);

    editor_pkg::cursor_pos_t pos_q;
    editor_pkg::row_t        next_row;
    editor_pkg::row_t        prev_row;
    editor_pkg::cursor_pos_t adv_pos;
    editor_pkg::cursor_pos_t back_pos;
    editor_pkg::cursor_pos_t new_pos;

    assign next_row = (pos_q.row == LAST_ROW) ? '0 : pos_q.row + 1'b1;
    assign prev_row = (pos_q.row == '0) ? LAST_ROW : pos_q.row - 1'b1;

    always_comb
    begin
        if (pos_q.col == LAST_COL)  // Wrap to start of next line
        begin
            adv_pos.col = '0;
            adv_pos.row = next_row;
        end
        else
        begin
            adv_pos.col = pos_q.col + 1'b1;
            adv_pos.row = pos_q.row;
        end

        if (pos_q.col == '0)
        begin
            back_pos.col = LAST_COL;
            back_pos.row = prev_row;
        end
        else
        begin
            back_pos.col = pos_q.col - 1'b1;
            back_pos.row = pos_q.row;
        end
    end

    always_comb
    begin
        new_pos = pos_q;
        if (key.kind == editor_pkg::KEY_PRINT)
            new_pos = adv_pos;
        else
        begin
            case (key.move)
                editor_pkg::MOVE_UP:    new_pos.row = prev_row;
                editor_pkg::MOVE_DOWN:  new_pos.row = next_row;
                editor_pkg::MOVE_LEFT:  new_pos = back_pos;
                editor_pkg::MOVE_RIGHT: new_pos = adv_pos;
                editor_pkg::MOVE_HOME:  new_pos.col = '0;
                editor_pkg::MOVE_END:   new_pos.col = LAST_COL;
                default:                new_pos = pos_q;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pos_q       <= '0;
            write_valid <= 1'b0;
        end
        else
        begin
            write_valid <= key_valid && (key.kind == editor_pkg::KEY_PRINT);
            if (key_valid)
                pos_q <= new_pos;
        end
    end

    // Character lands at the position before the advance
    always_ff @(posedge clk)
    begin
        if (key_valid)
        begin
            cell_write.pos <= pos_q;
            cell_write.ch  <= key.ch;
        end
    end

    assign cursor.pos     = pos_q;
    assign cursor.visible = cursor_on;

endmodule

// ==== cursor_blink.sv ====
module cursor_blink
#(
    parameter int BLINK_DIV = 25_000_000
)
(
    input  logic clk,
    input  logic reset,
    input  logic key_valid,
    output logic cursor_on
);

    localparam int               CNT_W  = $clog2(BLINK_DIV + 1);
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(BLINK_DIV - 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk)
    begin
        if (reset || key_valid)  // Solid while typing
        begin
            count     <= RELOAD;
            cursor_on <= 1'b1;
        end
        else if (count == '0)
        begin
            count     <= RELOAD;
            cursor_on <= ~cursor_on;
        end
        else
            count <= count - 1'b1;
    end

endmodule

// ==== key_decoder.sv ====
module key_decoder
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    byte_valid,
    input  editor_pkg::scan_t       rx_byte,
    output logic                    key_valid,
    output editor_pkg::key_event_t  key
);

    logic                   break_q;
    logic                   extend_q;
    logic                   shift_q;
    editor_pkg::ascii_t     char_code;
    logic                   char_hit;
    logic                   is_letter;
    editor_pkg::move_e      move_code;
    logic                   move_hit;
    logic                   is_shift;
    logic                   event_hit;
    editor_pkg::key_event_t next_key;

    // Letters as lower case, digits and space
    always_comb
    begin
        case (rx_byte)
            8'h1C: char_code = 7'h61;
            8'h32: char_code = 7'h62;
            8'h21: char_code = 7'h63;
            8'h23: char_code = 7'h64;
            8'h24: char_code = 7'h65;
            8'h2B: char_code = 7'h66;
            8'h34: char_code = 7'h67;
            8'h33: char_code = 7'h68;
            8'h43: char_code = 7'h69;
            8'h3B: char_code = 7'h6A;
            8'h42: char_code = 7'h6B;
            8'h4B: char_code = 7'h6C;
            8'h3A: char_code = 7'h6D;
            8'h31: char_code = 7'h6E;
            8'h44: char_code = 7'h6F;
            8'h4D: char_code = 7'h70;
            8'h15: char_code = 7'h71;
            8'h2D: char_code = 7'h72;
            8'h1B: char_code = 7'h73;
            8'h2C: char_code = 7'h74;
            8'h3C: char_code = 7'h75;
            8'h2A: char_code = 7'h76;
            8'h1D: char_code = 7'h77;
            8'h22: char_code = 7'h78;
            8'h35: char_code = 7'h79;
            8'h1A: char_code = 7'h7A;
            8'h45: char_code = 7'h30;
            8'h16: char_code = 7'h31;
            8'h1E: char_code = 7'h32;
            8'h26: char_code = 7'h33;
            8'h25: char_code = 7'h34;
            8'h2E: char_code = 7'h35;
            8'h36: char_code = 7'h36;
            8'h3D: char_code = 7'h37;
            8'h3E: char_code = 7'h38;
            8'h46: char_code = 7'h39;
            8'h29: char_code = 7'h20;  // Space
            default: char_code = '0;
        endcase
    end

    assign char_hit  = (char_code != '0);
    assign is_letter = (char_code >= 7'h61) && (char_code <= 7'h7A);

    always_comb
    begin
        move_hit  = 1'b1;
        move_code = editor_pkg::MOVE_UP;
        case (rx_byte)
            8'h75: move_code = editor_pkg::MOVE_UP;
            8'h72: move_code = editor_pkg::MOVE_DOWN;
            8'h6B: move_code = editor_pkg::MOVE_LEFT;
            8'h74: move_code = editor_pkg::MOVE_RIGHT;
            8'h6C: move_code = editor_pkg::MOVE_HOME;
            8'h69: move_code = editor_pkg::MOVE_END;
            default: move_hit = 1'b0;
        endcase
    end

    assign is_shift = !extend_q &&
                      (rx_byte == editor_pkg::SC_LSHIFT || rx_byte == editor_pkg::SC_RSHIFT);

    always_comb
    begin
        next_key.move = move_code;
        if (extend_q)
        begin
            next_key.kind = editor_pkg::KEY_MOVE;
            next_key.ch   = '0;
            event_hit     = move_hit;
        end
        else
        begin
            next_key.kind = editor_pkg::KEY_PRINT;
            next_key.ch   = (is_letter && shift_q) ? char_code - 7'h20 : char_code;
            event_hit     = char_hit;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            key_valid <= 1'b0;
            break_q   <= 1'b0;
            extend_q  <= 1'b0;
            shift_q   <= 1'b0;
        end
        else
        begin
            key_valid <= 1'b0;
            if (byte_valid)
            begin
                if (rx_byte == editor_pkg::SC_BREAK)
                    break_q <= 1'b1;
                else if (rx_byte == editor_pkg::SC_EXTEND)
                    extend_q <= 1'b1;
                else
                begin
                    break_q  <= 1'b0;
                    extend_q <= 1'b0;
                    if (is_shift)
                        shift_q <= !break_q;  // Make sets, release clears
                    else if (!break_q)
                        key_valid <= event_hit;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (byte_valid)
            key <= next_key;
    end

endmodule

// ==== ps2_receiver.sv ====
module ps2_receiver
(
    input  logic               clk,
    input  logic               reset,
    input  logic               ps2_clk,
    input  logic               ps2_dat,
    output logic               byte_valid,
    output editor_pkg::scan_t  rx_byte
);

    logic [1:0]            clk_sync;
    logic [1:0]            dat_sync;
    logic                  clk_prev;
    logic                  fall;
    editor_pkg::rx_state_e state;
    logic [2:0]            bit_cnt;
    logic                  parity_bit;
    editor_pkg::scan_t     shift_q;

    // Both lines idle high
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end
        else
        begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    assign fall = clk_prev & ~clk_sync[1];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= editor_pkg::RX_IDLE;
            bit_cnt    <= '0;
            byte_valid <= 1'b0;
        end
        else
        begin
            byte_valid <= 1'b0;
            if (fall)
            begin
                case (state)
                    editor_pkg::RX_IDLE:
                    begin
                        bit_cnt <= '0;
                        if (!dat_sync[1])  // Start bit
                            state <= editor_pkg::RX_DATA;
                    end
                    editor_pkg::RX_DATA:
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7)
                            state <= editor_pkg::RX_PARITY;
                    end
                    editor_pkg::RX_PARITY:
                        state <= editor_pkg::RX_STOP;
                    editor_pkg::RX_STOP:
                    begin
                        // Odd parity over data and parity, stop must be high
                        byte_valid <= dat_sync[1] & (^{shift_q, parity_bit});
                        state      <= editor_pkg::RX_IDLE;
                    end
                    default:
                        state <= editor_pkg::RX_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (fall && state == editor_pkg::RX_DATA)
            shift_q <= {dat_sync[1], shift_q[7:1]};  // LSB first
        if (fall && state == editor_pkg::RX_PARITY)
            parity_bit <= dat_sync[1];
    end

    assign rx_byte = shift_q;

endmodule

// ==== editor_pkg.sv ====
package editor_pkg;

    typedef logic [7:0] scan_t;
    typedef logic [6:0] ascii_t;
    typedef logic [5:0] col_t;
    typedef logic [3:0] row_t;

    typedef enum logic
    {
        KEY_PRINT,
        KEY_MOVE
    } key_kind_e;

    typedef enum logic [2:0]
    {
        MOVE_UP,
        MOVE_DOWN,
        MOVE_LEFT,
        MOVE_RIGHT,
        MOVE_HOME,
        MOVE_END
    } move_e;

    typedef struct packed
    {
        key_kind_e kind;
        ascii_t    ch;    // Only for KEY_PRINT
        move_e     move;  // Only for KEY_MOVE
    } key_event_t;

    typedef struct packed
    {
        col_t col;
        row_t row;
    } cursor_pos_t;

    typedef struct packed
    {
        cursor_pos_t pos;
        ascii_t      ch;
    } cell_write_t;

    typedef struct packed
    {
        cursor_pos_t pos;
        logic        visible;
    } cursor_out_t;

    typedef enum logic [1:0]
    {
        RX_IDLE,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_e;

    // Scan code set 2 prefixes and modifiers
    localparam scan_t SC_BREAK  = 8'hF0;
    localparam scan_t SC_EXTEND = 8'hE0;
    localparam scan_t SC_LSHIFT = 8'h12;
    localparam scan_t SC_RSHIFT = 8'h59;

endpackage
